/* verilog/isaPkg.sv */
package isaPkg;

    //////////////////////////////////////////////////////////////////////
    // Register numbers
    //////////////////////////////////////////////////////////////////////

    // Register 0 reads as zero and is never a hazard
    typedef logic [4:0] regNumT;

    localparam regNumT regZero = 5'd0;

    //////////////////////////////////////////////////////////////////////
    // Opcode and function fields
    //////////////////////////////////////////////////////////////////////

    typedef logic [5:0] opcodeT;
    typedef logic [5:0] functT;

    // Primary opcodes of the supported subset
    localparam opcodeT opSpecial = 6'b000000;
    localparam opcodeT opOri     = 6'b001101;
    localparam opcodeT opLui     = 6'b001111;
    localparam opcodeT opLw      = 6'b100011;
    localparam opcodeT opSw      = 6'b101011;
    localparam opcodeT opBeq     = 6'b000100;

    // Function codes under opSpecial
    localparam functT fnAddu = 6'b100001;
    localparam functT fnSubu = 6'b100011;
    localparam functT fnJr   = 6'b001000;

    //////////////////////////////////////////////////////////////////////
    // Instruction word layout
    //////////////////////////////////////////////////////////////////////

    // R-type view of the word
    // I-type immediates sit in rd/shamt/funct and are not needed here
    typedef struct packed {
        opcodeT     opcode;
        regNumT     rs;
        regNumT     rt;
        regNumT     rd;
        logic [4:0] shamt;
        functT      funct;
    } instrFieldsT;

endpackage

/* verilog/hazardPkg.sv */
package hazardPkg;

    //////////////////////////////////////////////////////////////////////
    // Timing classes
    //////////////////////////////////////////////////////////////////////

    // Tuse: stages after D until an operand is consumed
    // Tnew: cycles until a result sits in a pipeline register
    typedef logic [1:0] timeT;

    localparam timeT tuseD = 2'd0;
    localparam timeT tuseE = 2'd1;
    localparam timeT tuseM = 2'd2;

    // Stages tracked after D (E, M, W)
    localparam int numTracked = 3;

    //////////////////////////////////////////////////////////////////////
    // Hazard records
    //////////////////////////////////////////////////////////////////////

    // One instruction's record as it travels E -> M -> W
    typedef struct packed {
        isaPkg::regNumT readA1;
        isaPkg::regNumT readA2;
        isaPkg::regNumT writeA;
        logic           regWrite;
        timeT           tnew;
    } hazRecT;

    // Sources of the instruction sitting in D
    typedef struct packed {
        isaPkg::regNumT readA1;
        isaPkg::regNumT readA2;
        timeT           tuse1;
        timeT           tuse2;
    } srcInfoT;

    //////////////////////////////////////////////////////////////////////
    // Forwarding selections
    //////////////////////////////////////////////////////////////////////

    // Positional codes, nearest eligible stage first
    typedef logic [1:0] selT;

    localparam selT selNone   = 2'b00;
    localparam selT selFirst  = 2'b01;
    localparam selT selSecond = 2'b10;
    localparam selT selThird  = 2'b11;

    typedef struct packed {
        selT d1;
        selT d2;
        selT e1;
        selT e2;
        selT m;
    } fwdSelT;

endpackage

/* verilog/instrDecoder.sv */
module instrDecoder (
    input  logic [31:0]        instr,
    output hazardPkg::srcInfoT src,
    output hazardPkg::hazRecT  rec
);

    import isaPkg::*;
    import hazardPkg::*;

    // Tnew as seen from D, one above the value held once in E
    // The stage register takes one off on every load
    localparam timeT tnewAluFromD  = 2'd2;
    localparam timeT tnewLoadFromD = 2'd3;

    instrFieldsT fields;

    regNumT readA1;
    regNumT readA2;
    timeT   tuse1;
    timeT   tuse2;
    regNumT writeA;
    logic   regWrite;
    timeT   tnew;

    assign fields = instrFieldsT'(instr);

    //////////////////////////////////////////////////////////////////////
    // Per-opcode source and destination selection
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        // Anything unrecognised behaves as a no-op
        readA1   = regZero;
        readA2   = regZero;
        tuse1    = tuseD;
        tuse2    = tuseD;
        writeA   = regZero;
        regWrite = 1'b0;
        tnew     = '0;

        case (fields.opcode)
            opSpecial: begin
                case (fields.funct)
                    fnAddu, fnSubu: begin
                        readA1   = fields.rs;
                        readA2   = fields.rt;
                        tuse1    = tuseE;
                        tuse2    = tuseE;
                        writeA   = fields.rd;
                        regWrite = 1'b1;
                        tnew     = tnewAluFromD;
                    end
                    fnJr: begin
                        // Jump target needed in D
                        readA1 = fields.rs;
                        tuse1  = tuseD;
                    end
                    default: begin
                    end
                endcase
            end
            opOri, opLui: begin
                readA1   = fields.rs;
                tuse1    = tuseE;
                writeA   = fields.rt;
                regWrite = 1'b1;
                tnew     = tnewAluFromD;
            end
            opLw: begin
                readA1   = fields.rs;
                tuse1    = tuseE;
                writeA   = fields.rt;
                regWrite = 1'b1;
                tnew     = tnewLoadFromD;
            end
            opSw: begin
                // Base used in E, store data not until M
                readA1 = fields.rs;
                readA2 = fields.rt;
                tuse1  = tuseE;
                tuse2  = tuseM;
            end
            opBeq: begin
                readA1 = fields.rs;
                readA2 = fields.rt;
                tuse1  = tuseD;
                tuse2  = tuseD;
            end
            default: begin
            end
        endcase
    end

    assign src = '{readA1: readA1, readA2: readA2, tuse1: tuse1, tuse2: tuse2};

    assign rec = '{readA1: readA1, readA2: readA2, writeA: writeA,
                   regWrite: regWrite, tnew: tnew};

    // Non-writing records must never hold up a consumer
    always_comb begin
        noWriteNoTnew: assert final (rec.regWrite || rec.tnew == '0)
            else $error("instrDecoder: tnew %0d on a non-writing record", rec.tnew);
    end

endmodule

/* verilog/stageRegister.sv */
module stageRegister (
    input  logic              clk,
    input  logic              rst,
    input  logic              bubble,
    input  hazardPkg::hazRecT recIn,
    output hazardPkg::hazRecT rec
);

    import hazardPkg::*;

    hazRecT aged;

    // Remaining latency relative to the stage being entered
    always_comb begin
        aged = recIn;
        if (recIn.tnew != '0) begin
            aged.tnew = recIn.tnew - 2'd1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Record register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            rec <= '0;
        end else if (bubble) begin
            // All-zero record is a no-op that writes nothing
            rec <= '0;
        end else begin
            rec <= aged;
        end
    end

    // The decoder may hand over 3, but once inside the pipe at most 2 remain
    tnewInRange: assert property (@(posedge clk) disable iff (rst) rec.tnew <= 2'd2)
        else $error("stageRegister: tnew %0d out of range", rec.tnew);

endmodule

/* verilog/transStallController.sv */
module transStallController (
    input  hazardPkg::srcInfoT src,
    input  hazardPkg::hazRecT  eRec,
    input  hazardPkg::hazRecT  mRec,
    input  hazardPkg::hazRecT  wRec,
    output hazardPkg::fwdSelT  fwdSel,
    output logic               stall
);

    import isaPkg::*;
    import hazardPkg::*;

    timeT pend1;
    timeT pend2;

    //////////////////////////////////////////////////////////////////////
    // Match helpers
    //////////////////////////////////////////////////////////////////////

    // Record writes this nonzero register
    function automatic logic writesReg(input regNumT a, input hazRecT r);
        return (a != regZero) && r.regWrite && (r.writeA == a);
    endfunction

    // Record writes this register and the value already exists
    function automatic logic readyFor(input regNumT a, input hazRecT r);
        return writesReg(a, r) && (r.tnew == '0);
    endfunction

    // D operands look at E, M, W in that order
    function automatic selT pickOfThree(input regNumT a, input hazRecT r1,
                                        input hazRecT r2, input hazRecT r3);
        if (readyFor(a, r1)) begin
            return selFirst;
        end
        if (readyFor(a, r2)) begin
            return selSecond;
        end
        if (readyFor(a, r3)) begin
            return selThird;
        end
        return selNone;
    endfunction

    // E operands look at M, then W
    function automatic selT pickOfTwo(input regNumT a, input hazRecT r1,
                                      input hazRecT r2);
        if (readyFor(a, r1)) begin
            return selFirst;
        end
        if (readyFor(a, r2)) begin
            return selSecond;
        end
        return selNone;
    endfunction

    // Tnew of the nearest record writing this register
    function automatic timeT pendingTnew(input regNumT a, input hazRecT r1,
                                         input hazRecT r2, input hazRecT r3);
        if (writesReg(a, r1)) begin
            return r1.tnew;
        end
        if (writesReg(a, r2)) begin
            return r2.tnew;
        end
        if (writesReg(a, r3)) begin
            return r3.tnew;
        end
        return '0;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Forwarding
    //////////////////////////////////////////////////////////////////////

    assign fwdSel.d1 = pickOfThree(src.readA1, eRec, mRec, wRec);
    assign fwdSel.d2 = pickOfThree(src.readA2, eRec, mRec, wRec);
    assign fwdSel.e1 = pickOfTwo(eRec.readA1, mRec, wRec);
    assign fwdSel.e2 = pickOfTwo(eRec.readA2, mRec, wRec);

    // Only the store data in M is still open
    assign fwdSel.m = readyFor(mRec.readA2, wRec) ? selFirst : selNone;

    //////////////////////////////////////////////////////////////////////
    // Stall
    //////////////////////////////////////////////////////////////////////

    assign pend1 = pendingTnew(src.readA1, eRec, mRec, wRec);
    assign pend2 = pendingTnew(src.readA2, eRec, mRec, wRec);

    // Producer too late for the point of use
    assign stall = (pend1 > src.tuse1) || (pend2 > src.tuse2);

    always_comb begin
        stallNeedsSource: assert final (!stall || src.readA1 != regZero ||
                                        src.readA2 != regZero)
            else $error("transStallController: stall without a D source");
    end

endmodule

/* verilog/hazardUnit.sv */
module hazardUnit (
    input  logic              clk,
    input  logic              rst,
    input  logic [31:0]       instr,
    output hazardPkg::fwdSelT fwdSel,
    output logic              stall
);

    import hazardPkg::*;

    srcInfoT decSrc;
    hazRecT  decRec;

    // Index 0 is E, 1 is M, 2 is W
    hazRecT stageIn  [numTracked];
    hazRecT stageOut [numTracked];

    logic [numTracked-1:0] bubbleReq;

    //////////////////////////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////////////////////////

    instrDecoder decoder0 (
        .instr (instr),
        .src   (decSrc),
        .rec   (decRec)
    );

    //////////////////////////////////////////////////////////////////////
    // Record chain
    //////////////////////////////////////////////////////////////////////

    // Only E takes bubbles, the later stages just drain
    assign bubbleReq = {{(numTracked - 1){1'b0}}, stall};

    assign stageIn[0] = decRec;

    for (genvar i = 0; i < numTracked; i++) begin : gStage
        if (i > 0) begin : gLink
            assign stageIn[i] = stageOut[i - 1];
        end

        stageRegister stage (
            .clk    (clk),
            .rst    (rst),
            .bubble (bubbleReq[i]),
            .recIn  (stageIn[i]),
            .rec    (stageOut[i])
        );
    end

    //////////////////////////////////////////////////////////////////////
    // Forwarding and stall
    //////////////////////////////////////////////////////////////////////

    transStallController ctrl0 (
        .src    (decSrc),
        .eRec   (stageOut[0]),
        .mRec   (stageOut[1]),
        .wRec   (stageOut[2]),
        .fwdSel (fwdSel),
        .stall  (stall)
    );

endmodule

/* include/benchVectors.svh */
`ifndef benchVectorsSvh
`define benchVectorsSvh

//////////////////////////////////////////////////////////////////////
// One row per cycle of the instruction in D
//////////////////////////////////////////////////////////////////////

typedef struct packed {
    logic [31:0] instr;
    logic        stall;
    fwdSelT      fwd;
} vecRowT;

vecRowT vectors[$];

// R-type word: rd = rs op rt
function automatic logic [31:0] rWord(input regNumT rs, input regNumT rt,
                                     input regNumT rd, input functT fn);
    return {opSpecial, rs, rt, rd, 5'd0, fn};
endfunction

// I-type word, rt is the destination or the store data
function automatic logic [31:0] iWord(input opcodeT op, input regNumT rs,
                                     input regNumT rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic fwdSelT fwdOf(input selT d1, input selT d2, input selT e1,
                                 input selT e2, input selT m);
    fwdSelT f;
    f.d1 = d1;
    f.d2 = d2;
    f.e1 = e1;
    f.e2 = e2;
    f.m  = m;
    return f;
endfunction

task automatic addRow(input logic [31:0] word, input logic stall, input fwdSelT fwd);
    vecRowT r;
    r.instr = word;
    r.stall = stall;
    r.fwd   = fwd;
    vectors.push_back(r);
endtask

task automatic loadVectors();
    logic [31:0] nop;
    fwdSelT      none;
    nop  = 32'h0000_0000;
    none = '0;
    // Empty pipe after reset
    addRow(nop, 1'b0, none);
    // addu r3 then addu reading r3, M forwards to E
    addRow(rWord(5'd1, 5'd2, 5'd3, fnAddu), 1'b0, none);
    addRow(rWord(5'd3, 5'd0, 5'd4, fnAddu), 1'b0, none);
    addRow(nop, 1'b0, fwdOf(selNone, selNone, selFirst, selNone, selNone));
    // One unrelated ori between producer and consumer
    addRow(rWord(5'd10, 5'd11, 5'd9, fnAddu), 1'b0, none);
    addRow(iWord(opOri, 5'd13, 5'd12, 16'h00ff), 1'b0, none);
    addRow(rWord(5'd9, 5'd0, 5'd14, fnAddu), 1'b0,
           fwdOf(selSecond, selNone, selNone, selNone, selNone));
    addRow(nop, 1'b0, fwdOf(selNone, selNone, selSecond, selNone, selNone));
    // Load use, one bubble then W forwards to E
    addRow(iWord(opLw, 5'd20, 5'd5, 16'h0000), 1'b0, none);
    addRow(rWord(5'd5, 5'd0, 5'd15, fnAddu), 1'b1, none);
    addRow(rWord(5'd5, 5'd0, 5'd15, fnAddu), 1'b0, none);
    addRow(nop, 1'b0, fwdOf(selNone, selNone, selSecond, selNone, selNone));
    // lw r6 then beq on r6, two bubbles
    addRow(iWord(opLw, 5'd21, 5'd6, 16'h0004), 1'b0, none);
    addRow(iWord(opBeq, 5'd6, 5'd0, 16'h0008), 1'b1, none);
    addRow(iWord(opBeq, 5'd6, 5'd0, 16'h0008), 1'b1, none);
    addRow(iWord(opBeq, 5'd6, 5'd0, 16'h0008), 1'b0,
           fwdOf(selThird, selNone, selNone, selNone, selNone));
    // addu r7 then beq on r7, one bubble
    addRow(rWord(5'd22, 5'd23, 5'd7, fnAddu), 1'b0, none);
    addRow(iWord(opBeq, 5'd7, 5'd0, 16'h0008), 1'b1, none);
    addRow(iWord(opBeq, 5'd7, 5'd0, 16'h0008), 1'b0,
           fwdOf(selSecond, selNone, selNone, selNone, selNone));
    // Store data from a load, beq r7 in E still sees r7 in W
    addRow(iWord(opLw, 5'd24, 5'd8, 16'h0000), 1'b0,
           fwdOf(selNone, selNone, selSecond, selNone, selNone));
    addRow(iWord(opSw, 5'd25, 5'd8, 16'h0000), 1'b0, none);
    addRow(nop, 1'b0, none);
    addRow(nop, 1'b0, fwdOf(selNone, selNone, selNone, selNone, selFirst));
    // Writes to r0 are ignored
    addRow(rWord(5'd1, 5'd2, 5'd0, fnSubu), 1'b0, none);
    addRow(iWord(opBeq, 5'd0, 5'd0, 16'h0008), 1'b0, none);
    addRow(rWord(5'd0, 5'd0, 5'd17, fnAddu), 1'b0, none);
    addRow(nop, 1'b0, none);
    // Two writers of r18, nearer one wins
    addRow(rWord(5'd1, 5'd2, 5'd18, fnAddu), 1'b0, none);
    addRow(iWord(opLui, 5'd0, 5'd18, 16'h1234), 1'b0, none);
    addRow(rWord(5'd18, 5'd18, 5'd19, fnAddu), 1'b0,
           fwdOf(selSecond, selSecond, selNone, selNone, selNone));
    addRow(rWord(5'd18, 5'd0, 5'd0, fnJr), 1'b0,
           fwdOf(selSecond, selNone, selFirst, selFirst, selNone));
    addRow(nop, 1'b0, fwdOf(selNone, selNone, selSecond, selNone, selFirst));
    addRow(nop, 1'b0, none);
endtask

`endif

/* bench/hazardBench.sv */
module hazardBench;

    import isaPkg::*;
    import hazardPkg::*;

    localparam int period      = 20;
    localparam int driveDelay  = 2;
    localparam int resetCycles = 2;
    localparam int slackCycles = 20;

    logic        clk;
    logic        rst;
    logic [31:0] instr;
    fwdSelT      fwdSel;
    logic        stall;

    int cycleCount = 0;
    int cycleLimit = 1000;

    `include "benchVectors.svh"

    hazardUnit dut0 (
        .clk    (clk),
        .rst    (rst),
        .instr  (instr),
        .fwdSel (fwdSel),
        .stall  (stall)
    );

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic failNow(input string msg);
        $display("ERR %0t %s", $time, msg);
        $display("TEST FAIL");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic checkStall(input int row, input logic got, input logic exp);
        if (got !== exp) begin
            failNow($sformatf("row %0d stall got %b expected %b", row, got, exp));
        end
    endtask

    task automatic checkFwd(input int row, input fwdSelT got, input fwdSelT exp);
        string names [5];
        int    bad;
        names = '{"d1", "d2", "e1", "e2", "m"};
        bad   = -1;
        // Field k sits at bits 9-2k and 8-2k, first mismatch is reported
        for (int k = 4; k >= 0; k--) begin
            if (got[9 - 2 * k -: 2] !== exp[9 - 2 * k -: 2]) begin
                bad = k;
            end
        end
        if (bad >= 0) begin
            failNow($sformatf("row %0d fwdSel.%s got %b expected %b", row, names[bad],
                              got[9 - 2 * bad -: 2], exp[9 - 2 * bad -: 2]));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Timeout
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: the vector table did not finish within %0d cycles",
                     cycleLimit);
            $display("TEST FAIL");
            $fatal(1, "timeout");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        rst   = 1'b1;
        instr = '0;
        loadVectors();
        cycleLimit = vectors.size() + slackCycles;
        repeat (resetCycles) @(posedge clk);
        #driveDelay;
        rst = 1'b0;
        foreach (vectors[i]) begin
            instr = vectors[i].instr;
            // Sample one unit before the next rising edge
            #(period - driveDelay - 1);
            checkStall(i, stall, vectors[i].stall);
            checkFwd(i, fwdSel, vectors[i].fwd);
            @(posedge clk);
            #driveDelay;
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+include
verilog/isaPkg.sv
verilog/hazardPkg.sv
verilog/instrDecoder.sv
verilog/stageRegister.sv
verilog/transStallController.sv
verilog/hazardUnit.sv
bench/hazardBench.sv

/* Bender.yml */
package:
  name: hazard_unit

sources:
  - files:
      - verilog/isaPkg.sv
      - verilog/hazardPkg.sv
      - verilog/instrDecoder.sv
      - verilog/stageRegister.sv
      - verilog/transStallController.sv
      - verilog/hazardUnit.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/hazardBench.sv
